// File: dv/hba_bus_props.sv
/*
 * HBA bus handshake assertions
 * Bound into the interconnect, watches the master side
 */
module hba_bus_props import hba_pkg::*; (
    input logic     hba_clk,
    input logic     hba_reset,
    input hba_req_t master_req,
    input hba_rsp_t master_rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;  // Failed assertion count

    // Single cycle acknowledge
    ack_one_cycle: assert property (@(posedge hba_clk) disable iff (hba_reset)
        master_rsp.xferack |=> !master_rsp.xferack)
        else begin
            $error("xferack lasted two cycles");
            failures++;
        end

    // Request frozen from select rise until the acknowledge
    req_stable: assert property (@(posedge hba_clk) disable iff (hba_reset)
        master_req.select && !master_rsp.xferack |=> $stable(master_req))
        else begin
            $error("bus request changed before xferack");
            failures++;
        end

    rdata_idle_zero: assert property (@(posedge hba_clk) disable iff (hba_reset)
        !master_rsp.xferack |-> master_rsp.dbus == '0)
        else begin
            $error("read data not zero outside xferack");
            failures++;
        end

    select_drop: assert property (@(posedge hba_clk) disable iff (hba_reset)
        master_rsp.xferack |=> !master_req.select)
        else begin
            $error("select still high after xferack");
            failures++;
        end

    addr_idle_zero: assert property (@(posedge hba_clk) disable iff (hba_reset)
        !master_req.select |-> master_req.abus == '0)
        else begin
            $error("address not zero while select is low");
            failures++;
        end

endmodule

// File: dv/hba_checker.sv
/*
 * Reply monitor on io_txd
 * Decodes serial bytes at mid-bit, compares them with the expected
 * queue and keeps the per-test and total counts
 */
module hba_checker import hba_pkg::*; (
    input logic hba_clk,
    input logic hba_reset,
    input logic io_txd,
    input logic io_intr
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] expected [$];
    int         pending       = 0;  // Reply bytes still owed
    int         errors        = 0;
    int         errors_before = 0;  // Error count when current test began
    int         checked       = 0;
    int         tests         = 0;

    task automatic expect_byte(input logic [7:0] b);
        expected.push_back(b);
        pending++;
    endtask

    // Serial receiver model
    initial begin
        logic [7:0] rx_byte;
        logic [7:0] exp_byte;
        forever begin
            @(posedge hba_clk);
            if (!hba_reset && io_txd === 1'b0) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(posedge hba_clk);  // Middle of start bit
                for (int b = 0; b < 8; b++) begin
                    repeat (CLKS_PER_BIT) @(posedge hba_clk);
                    rx_byte[b] = io_txd;  // LSB first
                end
                repeat (CLKS_PER_BIT) @(posedge hba_clk);
                if (io_txd !== 1'b1) begin
                    $display("no valid stop bit on io_txd after byte 0x%02h", rx_byte);
                    errors++;
                end
                if (pending == 0) begin
                    $display("unexpected reply byte 0x%02h on io_txd", rx_byte);
                    errors++;
                end else begin
                    exp_byte = expected.pop_front();
                    pending--;
                    checked++;
                    if (rx_byte !== exp_byte) begin
                        $display("MISMATCH io_txd expected 0x%02h got 0x%02h", exp_byte, rx_byte);
                        errors++;
                    end
                end
            end
        end
    end

    // Line idle and interrupt pin low for a while
    task automatic check_idle(input int cycles);
        int bad;
        bad = 0;
        repeat (cycles) begin
            @(posedge hba_clk);
            if (io_txd !== 1'b1 || io_intr !== 1'b0)
                bad++;
        end
        if (bad != 0) begin
            $display("io_txd or io_intr left its idle level for %0d cycles", bad);
            errors++;
        end
    endtask

    task automatic check_intr(input logic level);
        @(posedge hba_clk);
        if (io_intr !== level) begin
            $display("MISMATCH io_intr expected 0x%0h got 0x%0h", level, io_intr);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (pending != 0) begin
            $display("%0d reply bytes never arrived in test %s", pending, name);
            errors++;
            expected.delete();
            pending = 0;
        end
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        errors_before = errors;
    endtask

endmodule

// File: dv/tb_serial_hba.sv
/*
 * Serial to HBA bridge testbench
 * Sends commands on io_rxd, models the bank and interrupt registers
 * and hands the expected reply bytes to the monitor
 */
module tb_serial_hba
    import hba_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic        hba_clk;
    logic        hba_reset;
    logic        io_rxd;
    logic        io_txd;
    logic [15:0] slave_interrupt;
    logic        io_intr;

    logic [15:0] lfsr_q;                  // Fibonacci LFSR state
    logic [7:0]  bank_model [BANK_REGS];
    logic [7:0]  intr_model [2];
    logic [7:0]  wdata [8];               // Data bytes of the next write
    logic [7:0]  reply [11];              // Expected reply of the next command

    serial_hba_top UUT (.hba_clk, .hba_reset, .io_rxd, .io_txd, .slave_interrupt, .io_intr);
    hba_checker monitor (.hba_clk, .hba_reset, .io_txd, .io_intr);
    bind hba_bus hba_bus_props props (.hba_clk, .hba_reset, .master_req, .master_rsp);

    initial begin
        hba_clk = 1'b0;
        forever #4 hba_clk = ~hba_clk;
    end

    // Taps 16 14 13 11
    function automatic logic next_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++)
            b[i] = next_bit();
        return b;
    endfunction

    // Expected reply bytes, updates the register model
    function automatic int expected_reply(input logic [7:0] cmd, input logic [7:0] addr);
        int         n;
        logic [7:0] a;
        n = 0;
        if (cmd[7]) begin
            reply[0] = cmd;  // Echo
            reply[1] = addr;
            n = 2;
        end
        for (int i = 0; i <= int'(cmd[6:4]); i++) begin
            a = addr + 8'(i);  // Wraps at 8 bits
            if (cmd[7]) begin
                if (cmd[3:0] == BANK_PERIPH)
                    reply[n] = (a < BANK_REGS) ? bank_model[a[2:0]] : UNMAPPED_DATA;
                else if (cmd[3:0] == INTR_PERIPH) begin
                    reply[n] = (a < 2) ? intr_model[a[0]] : 8'h00;
                    if (a < 2)
                        intr_model[a[0]] = 8'h00;  // Clear on read
                end else
                    reply[n] = UNMAPPED_DATA;
                n++;
            end else if (cmd[3:0] == BANK_PERIPH && a < BANK_REGS)
                bank_model[a[2:0]] = wdata[i];
            else if (cmd[3:0] == INTR_PERIPH && a < 2)
                intr_model[a[0]] = intr_model[a[0]] | wdata[i];
        end
        if (!cmd[7]) begin
            reply[n] = ACK_CHAR;
            n++;
        end
        return n;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // Stop, data, start
        for (int i = 0; i < 10; i++) begin
            @(posedge hba_clk);
            io_rxd <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge hba_clk);
        end
    endtask

    // Full command, then wait for the reply within its latency bound
    task automatic run_command(input logic [7:0] cmd, input logic [7:0] addr);
        int n;
        int count;
        int waited;
        n     = expected_reply(cmd, addr);
        count = int'(cmd[6:4]) + 1;
        for (int i = 0; i < n; i++)
            monitor.expect_byte(reply[i]);
        send_byte(cmd);
        send_byte(addr);
        for (int i = 0; i < count && !cmd[7]; i++)
            send_byte(wdata[i]);
        waited = 0;
        while (monitor.pending != 0 && waited < (count + 3) * 10 * CLKS_PER_BIT +
                                                count * HBA_TIMEOUT) begin
            @(posedge hba_clk);
            waited++;
        end
        if (monitor.pending != 0) begin
            $display("reply to command 0x%02h incomplete within its latency bound", cmd);
            monitor.errors++;
        end
    endtask

    task automatic pulse_interrupts(input logic [15:0] lines);
        @(posedge hba_clk);
        slave_interrupt <= lines;
        @(posedge hba_clk);
        slave_interrupt <= '0;
        intr_model[0] = intr_model[0] | lines[7:0];
        intr_model[1] = intr_model[1] | lines[15:8];
    endtask

    initial begin
        int total_errors;
        hba_reset       = 1'b1;
        io_rxd          = 1'b1;
        slave_interrupt = '0;
        lfsr_q          = 16'd11;
        for (int r = 0; r < BANK_REGS; r++)
            bank_model[r] = 8'h00;
        intr_model[0] = 8'h00;
        intr_model[1] = 8'h00;
        repeat (8) @(posedge hba_clk);
        hba_reset <= 1'b0;

        monitor.check_idle(4 * 10 * CLKS_PER_BIT);
        monitor.finish_test("idle after reset");

        for (int i = 0; i < 8; i++)
            wdata[i] = rand_byte();
        run_command(8'h71, 8'h00);  // Write 8 to bank
        monitor.finish_test("bank write");

        run_command(8'hF1, 8'h00);
        run_command(8'hA1, 8'h06);  // Runs past register 7
        monitor.finish_test("bank read");

        for (int i = 0; i < 8; i++)
            wdata[i] = rand_byte();
        run_command(8'h35, 8'h02);  // Peripheral 5, nobody home
        run_command(8'hF1, 8'h00);
        run_command(8'hB5, 8'h10);
        monitor.finish_test("unmapped peripheral");

        pulse_interrupts(16'h8421);
        repeat (3) @(posedge hba_clk);  // Capture then registered OR
        monitor.check_intr(1'b1);
        run_command(8'h90, 8'h00);
        run_command(8'h90, 8'h00);  // Cleared by the first read
        monitor.check_intr(1'b0);
        monitor.finish_test("interrupt capture");

        // Bus assertion failures count as errors too
        total_errors = monitor.errors + UUT.u_bus.props.failures;
        $display("%0d tests, %0d bytes checked, %0d errors",
                 monitor.tests, monitor.checked, total_errors);
        if (total_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // 300 byte times
    initial begin
        #(300 * 10 * CLKS_PER_BIT * 8);
        $display("watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: filelist.f
hdl/hba_pkg.sv
hdl/hba_uart.sv
hdl/hba_serial_bridge.sv
hdl/hba_intr_regs.sv
hdl/hba_reg_bank.sv
hdl/hba_bus.sv
hdl/serial_hba_top.sv
dv/hba_bus_props.sv
dv/hba_checker.sv
dv/tb_serial_hba.sv

// File: hdl/hba_bus.sv
/*
 * HBA bus interconnect
 * Decodes the peripheral field into slave selects, merges slave
 * responses and answers unclaimed transfers after a timeout
 */
module hba_bus import hba_pkg::*; (
    input  logic     hba_clk,
    input  logic     hba_reset,
    input  hba_req_t master_req,
    output hba_rsp_t master_rsp,
    output logic     intr_select,
    output logic     bank_select,
    input  hba_rsp_t intr_rsp,
    input  hba_rsp_t bank_rsp
);

    logic [PERIPH_ADDR_WIDTH-1:0] periph;
    logic [TIMEOUT_WIDTH-1:0]     wait_cnt;   // Cycles since select rose
    logic                         claimed;    // A slave acked this transfer
    logic                         to_ack;

    assign periph      = master_req.abus[ADDR_WIDTH-1 -: PERIPH_ADDR_WIDTH];
    assign intr_select = master_req.select && (periph == INTR_PERIPH);
    assign bank_select = master_req.select && (periph == BANK_PERIPH);

    // Idle responses are zero so a plain OR merges them
    assign master_rsp.xferack = intr_rsp.xferack | bank_rsp.xferack | to_ack;
    assign master_rsp.dbus    = intr_rsp.dbus | bank_rsp.dbus |
                                (to_ack ? UNMAPPED_DATA : '0);

    always_ff @(posedge hba_clk) begin
        if (hba_reset || !master_req.select) begin
            wait_cnt <= '0;
            claimed  <= 1'b0;
            to_ack   <= 1'b0;
        end else begin
            if (wait_cnt != '1)
                wait_cnt <= wait_cnt + 1'b1;  // Saturates
            claimed <= claimed | intr_rsp.xferack | bank_rsp.xferack;
            to_ack  <= !claimed && !to_ack &&
                       (wait_cnt == TIMEOUT_WIDTH'(HBA_TIMEOUT - 1));
        end
    end

endmodule

// File: hdl/hba_intr_regs.sv
/*
 * Interrupt register block, peripheral 0
 * Sticky capture of 16 interrupt lines into two clear-on-read
 * byte registers, with a registered interrupt pin
 */
module hba_intr_regs import hba_pkg::*; (
    input  logic        hba_clk,
    input  logic        hba_reset,
    input  hba_req_t    bus_req,
    input  logic        select,
    output hba_rsp_t    bus_rsp,
    input  logic [15:0] slave_interrupt,
    output logic        io_intr
);

    logic [1:0][7:0] intr_q;     // [0] lines 7:0, [1] lines 15:8
    logic            access;     // First cycle of a transfer
    logic            reg_hit;    // Register address 0 or 1
    logic            idx;

    assign access  = select && !bus_rsp.xferack;
    assign reg_hit = (bus_req.abus[REG_ADDR_WIDTH-1:1] == '0);
    assign idx     = bus_req.abus[0];

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            intr_q  <= '0;
            bus_rsp <= '0;
            io_intr <= 1'b0;
        end else begin
            bus_rsp.xferack <= access;  // Every address is claimed
            bus_rsp.dbus    <= '0;
            if (access && reg_hit && bus_req.rnw)
                bus_rsp.dbus <= intr_q[idx];
            for (int r = 0; r < 2; r++) begin
                // Clear on read, OR on write, new pulse wins over clear
                if (access && reg_hit && idx == r[0])
                    intr_q[r] <= (bus_req.rnw ? 8'h00 : intr_q[r] | bus_req.dbus)
                                 | slave_interrupt[r*8 +: 8];
                else
                    intr_q[r] <= intr_q[r] | slave_interrupt[r*8 +: 8];
            end
            io_intr <= |intr_q;
        end
    end

endmodule

// File: hdl/hba_pkg.sv
/*
 * HBA serial bridge shared definitions
 * Bus widths, serial timing, protocol characters and the bus
 * request and response structs used by every block
 */
package hba_pkg;

    // Bus address split into peripheral and register fields
    localparam int PERIPH_ADDR_WIDTH = 4;
    localparam int REG_ADDR_WIDTH    = 8;
    localparam int ADDR_WIDTH        = PERIPH_ADDR_WIDTH + REG_ADDR_WIDTH;
    localparam int DBUS_WIDTH        = 8;

    // Serial timing, one byte is 10 bit periods
    localparam int CLKS_PER_BIT  = 8;   // Must be 4 or more
    localparam int BIT_CNT_WIDTH = $clog2(CLKS_PER_BIT);

    // Interconnect answers unclaimed transfers after this many cycles
    localparam int HBA_TIMEOUT   = 16;
    localparam int TIMEOUT_WIDTH = $clog2(HBA_TIMEOUT + 1);

    // Protocol characters
    localparam logic [DBUS_WIDTH-1:0] ACK_CHAR      = 8'hAC;
    localparam logic [DBUS_WIDTH-1:0] UNMAPPED_DATA = 8'hFF;

    // Peripheral map
    localparam logic [PERIPH_ADDR_WIDTH-1:0] INTR_PERIPH = 4'd0;
    localparam logic [PERIPH_ADDR_WIDTH-1:0] BANK_PERIPH = 4'd1;

    localparam int BANK_REGS      = 8;
    localparam int BANK_IDX_WIDTH = $clog2(BANK_REGS);

    // Master to slave request, address zero while select is low
    typedef struct packed {
        logic                  select;
        logic                  rnw;     // 1 = read
        logic [ADDR_WIDTH-1:0] abus;
        logic [DBUS_WIDTH-1:0] dbus;    // Write data
    } hba_req_t;

    // Slave to master response, all zero when not acknowledging
    typedef struct packed {
        logic                  xferack;
        logic [DBUS_WIDTH-1:0] dbus;    // Read data
    } hba_rsp_t;

endpackage

// File: hdl/hba_reg_bank.sv
/*
 * Read/write register bank, peripheral 1
 * Eight byte registers, higher addresses left to the bus timeout
 */
module hba_reg_bank import hba_pkg::*; (
    input  logic     hba_clk,
    input  logic     hba_reset,
    input  hba_req_t bus_req,
    input  logic     select,
    output hba_rsp_t bus_rsp
);

    logic [BANK_REGS-1:0][DBUS_WIDTH-1:0] bank_q;
    logic                                 hit;
    logic [BANK_IDX_WIDTH-1:0]            idx;

    assign idx = bus_req.abus[BANK_IDX_WIDTH-1:0];

    // Claim only the first cycle of a transfer to a real register
    assign hit = select && !bus_rsp.xferack &&
                 (bus_req.abus[REG_ADDR_WIDTH-1:0] < REG_ADDR_WIDTH'(BANK_REGS));

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            bank_q  <= '0;
            bus_rsp <= '0;
        end else begin
            bus_rsp.xferack <= hit;  // One cycle after select rises
            bus_rsp.dbus    <= (hit && bus_req.rnw) ? bank_q[idx] : '0;
            if (hit && !bus_req.rnw)
                bank_q[idx] <= bus_req.dbus;  // Visible in ack cycle
        end
    end

endmodule

// File: hdl/hba_serial_bridge.sv
/*
 * Serial command sequencer and HBA bus master
 * Reads command and register address bytes, runs one bus transfer
 * per data byte, echoes reads and acknowledges writes
 */
module hba_serial_bridge import hba_pkg::*; (
    input  logic       hba_clk,
    input  logic       hba_reset,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    output logic       rx_take,
    output logic       tx_start,
    output logic [7:0] tx_data,
    input  logic       tx_ready,
    output hba_req_t   bus_req,
    input  hba_rsp_t   bus_rsp
);

    typedef enum logic [3:0] {
        S_CMD,
        S_ADDR,
        S_ECHO_CMD,
        S_ECHO_ADDR,
        S_GET_DATA,
        S_BUS,
        S_SEND_DATA,
        S_STEP,
        S_ACK
    } state_t;

    state_t                    state;
    logic [7:0]                cmd_q;       // rnw, count-1, peripheral
    logic [REG_ADDR_WIDTH-1:0] reg_addr_q;
    logic [DBUS_WIDTH-1:0]     data_q;      // Write data or read result
    logic [2:0]                count_q;     // Transfers left after this one
    logic                      is_read;

    assign is_read = cmd_q[7];

    // Byte handshakes complete in the cycle they are offered
    assign rx_take  = rx_valid &&
                      (state == S_CMD || state == S_ADDR || state == S_GET_DATA);
    assign tx_start = tx_ready &&
                      (state == S_ECHO_CMD || state == S_ECHO_ADDR ||
                       state == S_SEND_DATA || state == S_ACK);

    always_comb begin
        case (state)
            S_ECHO_CMD:  tx_data = cmd_q;
            S_ECHO_ADDR: tx_data = reg_addr_q;
            S_ACK:       tx_data = ACK_CHAR;
            default:     tx_data = data_q;
        endcase
    end

    // Request held stable for the whole S_BUS state, zero otherwise
    always_comb begin
        bus_req        = '0;
        bus_req.select = (state == S_BUS);
        if (bus_req.select) begin
            bus_req.rnw  = is_read;
            bus_req.abus = {cmd_q[3:0], reg_addr_q};
            bus_req.dbus = is_read ? '0 : data_q;
        end
    end

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            state   <= S_CMD;
            count_q <= '0;
        end else begin
            case (state)
                S_CMD: begin
                    if (rx_valid) begin
                        cmd_q <= rx_data;
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (rx_valid) begin
                        reg_addr_q <= rx_data;
                        count_q    <= cmd_q[6:4];
                        state      <= is_read ? S_ECHO_CMD : S_GET_DATA;
                    end
                end
                S_ECHO_CMD: begin
                    if (tx_ready)
                        state <= S_ECHO_ADDR;
                end
                S_ECHO_ADDR: begin
                    if (tx_ready)
                        state <= S_BUS;
                end
                S_GET_DATA: begin
                    if (rx_valid) begin
                        data_q <= rx_data;
                        state  <= S_BUS;
                    end
                end
                S_BUS: begin
                    // Select drops the cycle after the acknowledge
                    if (bus_rsp.xferack) begin
                        data_q <= bus_rsp.dbus;
                        state  <= is_read ? S_SEND_DATA : S_STEP;
                    end
                end
                S_SEND_DATA: begin
                    if (tx_ready)
                        state <= S_STEP;
                end
                S_STEP: begin
                    if (count_q == '0) begin
                        state <= is_read ? S_CMD : S_ACK;
                    end else begin
                        count_q    <= count_q - 1'b1;
                        reg_addr_q <= reg_addr_q + 1'b1;  // Wraps at 8 bits
                        state      <= is_read ? S_BUS : S_GET_DATA;
                    end
                end
                S_ACK: begin
                    if (tx_ready)
                        state <= S_CMD;
                end
                default: state <= S_CMD;
            endcase
        end
    end

endmodule

// File: hdl/hba_uart.sv
/*
 * 8N1 UART
 * Receiver with one byte holding register and handshake to the
 * bridge, transmitter with a ready flag that drops for a whole byte
 */
module hba_uart import hba_pkg::*; (
    input  logic       hba_clk,
    input  logic       hba_reset,
    input  logic       io_rxd,
    output logic       io_txd,
    output logic       rx_valid,
    output logic [7:0] rx_data,
    input  logic       rx_take,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx_ready
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t                rx_state;
    logic                     rxd_meta, rxd_sync;
    logic [BIT_CNT_WIDTH-1:0] rx_cnt;
    logic [2:0]               rx_bits;
    logic [7:0]               rx_shift;

    logic                     tx_busy;
    logic [BIT_CNT_WIDTH-1:0] tx_cnt;
    logic [3:0]               tx_bits;
    logic [8:0]               tx_shift;  // Data bits then stop bit

    assign tx_ready = ~tx_busy;

    // Two flop synchronizer, line idles high
    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= io_rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
            rx_bits  <= '0;
            rx_valid <= 1'b0;
        end else begin
            if (rx_take)
                rx_valid <= 1'b0;  // Bridge consumed the byte
            rx_cnt <= rx_cnt + 1'b1;
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rxd_sync)
                        rx_state <= RX_START;  // Falling edge of start bit
                end
                RX_START: begin
                    // Recheck at mid start bit, filters glitches
                    if (rx_cnt == BIT_CNT_WIDTH'(CLKS_PER_BIT / 2 - 1)) begin
                        rx_cnt   <= '0;
                        rx_bits  <= '0;
                        rx_state <= rxd_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (rx_cnt == BIT_CNT_WIDTH'(CLKS_PER_BIT - 1)) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rxd_sync, rx_shift[7:1]};  // LSB first
                        rx_bits  <= rx_bits + 1'b1;
                        if (rx_bits == 3'd7)
                            rx_state <= RX_STOP;
                    end
                end
                default: begin
                    if (rx_cnt == BIT_CNT_WIDTH'(CLKS_PER_BIT - 1)) begin
                        // Valid stop bit and free holding register, else drop
                        if (rxd_sync && !rx_valid) begin
                            rx_data  <= rx_shift;
                            rx_valid <= 1'b1;
                        end
                        rx_state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            tx_busy <= 1'b0;
            tx_cnt  <= '0;
            tx_bits <= '0;
            io_txd  <= 1'b1;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy  <= 1'b1;
                tx_shift <= {1'b1, tx_data};
                tx_cnt   <= '0;
                tx_bits  <= '0;
                io_txd   <= 1'b0;  // Start bit
            end
        end else if (tx_cnt == BIT_CNT_WIDTH'(CLKS_PER_BIT - 1)) begin
            tx_cnt <= '0;
            if (tx_bits == 4'd9) begin
                tx_busy <= 1'b0;  // End of stop bit
                io_txd  <= 1'b1;
            end else begin
                io_txd   <= tx_shift[0];
                tx_shift <= {1'b1, tx_shift[8:1]};
                tx_bits  <= tx_bits + 1'b1;
            end
        end else begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

endmodule

// File: hdl/serial_hba_top.sv
/*
 * Serial to HBA bridge top level
 * UART, bridge master, interconnect and two peripherals
 */
module serial_hba_top import hba_pkg::*; (
    input  logic        hba_clk,
    input  logic        hba_reset,
    input  logic        io_rxd,
    output logic        io_txd,
    input  logic [15:0] slave_interrupt,
    output logic        io_intr
);

    logic       rx_valid, rx_take;
    logic [7:0] rx_data;
    logic       tx_start, tx_ready;
    logic [7:0] tx_data;

    hba_req_t   bus_req;
    hba_rsp_t   bus_rsp, intr_rsp, bank_rsp;
    logic       intr_select, bank_select;

    hba_uart u_uart (
        .hba_clk, .hba_reset, .io_rxd, .io_txd,
        .rx_valid, .rx_data, .rx_take,
        .tx_start, .tx_data, .tx_ready
    );

    hba_serial_bridge u_bridge (
        .hba_clk, .hba_reset,
        .rx_valid, .rx_data, .rx_take,
        .tx_start, .tx_data, .tx_ready,
        .bus_req, .bus_rsp
    );

    hba_bus u_bus (
        .hba_clk, .hba_reset,
        .master_req (bus_req),
        .master_rsp (bus_rsp),
        .intr_select, .bank_select,
        .intr_rsp, .bank_rsp
    );

    hba_intr_regs u_intr (
        .hba_clk, .hba_reset, .bus_req,
        .select (intr_select),
        .bus_rsp (intr_rsp),
        .slave_interrupt, .io_intr
    );

    hba_reg_bank u_bank (
        .hba_clk, .hba_reset, .bus_req,
        .select (bank_select),
        .bus_rsp (bank_rsp)
    );

endmodule
